// File: uart_top.f
uart_pkg.sv
uart_bus_regs.sv
uart_tx_serializer.sv
uart_rx_sampler.sv
uart_top.sv
uart_sva.sv
uart_checker.sv
tb_uart_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_uart_top \
    -f uart_top.f --Mdir obj_dir -o sim_uart
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_uart)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: tb_uart_top.sv
`timescale 1ns/10ps

module tb_uart_top;

    import uart_pkg::*;

    localparam int DIV_W        = 16;
    localparam int N_RAND       = 10;                           // random loopback bytes
    localparam int N_FRAMES     = N_RAND + 2;                   // plus pending and rx-off frames
    localparam int FRAME_CYC    = 10 * 16;                      // one frame at divider 15
    localparam int LIMIT_CYCLES = 3 * (N_FRAMES + 2) * FRAME_CYC + 1280;   // 8000 cycles
    localparam logic [31 : 0] BASE = 32'h1000_0000;            // decode uses addr[3:0] only
    localparam logic [31 : 0] A_CR = BASE | 32'(UART_CR);
    localparam logic [31 : 0] A_TX = BASE | 32'(UART_TX);
    localparam logic [31 : 0] A_RX = BASE | 32'(UART_RX);
    localparam logic [31 : 0] A_DR = BASE | 32'(UART_DR);

    logic               clk = 1'b0;
    logic               rst_n;
    logic   [31 : 0]    addr;
    logic               we;
    logic   [31 : 0]    wd;
    logic   [31 : 0]    rd;
    logic               uart_tx;
    wire                loopback;                               // tx pin fed back to rx
    logic               exp_valid;                              // checker compares rd
    logic   [31 : 0]    exp_data;
    int                 chk_errs;
    int                 frames_done;
    int                 seq_errs = 0;
    int                 cycle_cnt = 0;
    logic   [15 : 0]    lfsr = 16'd29192;
    logic   [15 : 0]    rnd;                                    // bits taken from lfsr
    int                 div;
    logic   [7 : 0]     data;
    int                 frames_before;

    assign loopback = uart_tx;

    always #50 clk = ~clk;                                      // 100 ns period

    uart_top #(.DIV_W(DIV_W)) DUT (.*, .uart_rx(loopback));

    uart_checker #(.DIV_W(DIV_W)) u_check (.*, .err_cnt(chk_errs), .frames_done(frames_done));

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    initial
    begin
        wait (cycle_cnt == LIMIT_CYCLES);
        $display("timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
        $display("Result: FAILED");
        $finish;
    end

    function automatic logic [15 : 0] lfsr_next(input logic [15 : 0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);         // taps 16 14 13 11
    endfunction

    task automatic take_bits(input int n);
        rnd = '0;
        for (int i = 0; i < n; i++)
        begin
            rnd  = {rnd[14 : 0], lfsr[0]};                      // one step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [31 : 0] ctrl_word(input logic req, input logic val,
                                                input logic txe, input logic rxe);
        uart_ctrl_t c;
        c = '{rx_en: rxe, tx_en: txe, rx_val: val, tx_req: req};
        return {28'h0, c};
    endfunction

    task automatic bus_write(input logic [31 : 0] a, input logic [31 : 0] d);
        @(posedge clk);
        addr <= a;
        wd   <= d;
        we   <= 1'b1;
        @(posedge clk);
        we   <= 1'b0;                                           // single-cycle strobe
    endtask

    task automatic check_read(input logic [31 : 0] a, input logic [31 : 0] e);
        @(posedge clk);
        addr      <= a;
        exp_data  <= e;
        exp_valid <= 1'b1;                                      // compared on falling edge
        @(posedge clk);
        exp_valid <= 1'b0;
    endtask

    // wait for a control bit to reach a level
    task automatic poll_ctrl(input logic [4 : 0] b, input logic level, input int limit,
                             input string what);
        int n;
        n = 0;
        @(posedge clk);
        addr <= A_CR;
        @(negedge clk);
        while ((rd[b] !== level) && (n < limit))
        begin
            @(negedge clk);
            n++;
        end
        if (rd[b] !== level)
        begin
            seq_errs++;
            $display("%s did not happen within %0d cycles", what, limit);
        end
    endtask

    task automatic loopback_byte(input logic [7 : 0] b, input int d, input logic req);
        bus_write(A_DR, 32'(d));
        bus_write(A_TX, {24'h0, b});
        bus_write(A_CR, ctrl_word(req, 1'b0, 1'b1, 1'b1));
        check_read(A_CR, ctrl_word(1'b1, 1'b0, 1'b1, 1'b1));   // request in flight
        poll_ctrl(5'd0, 1'b0, 12 * (d + 1), "tx_req clear");
        poll_ctrl(5'd1, 1'b1, 4 * (d + 1), "rx_val set");
        check_read(A_RX, {24'h0, b});
    endtask

    initial
    begin
        rst_n     <= 1'b0;
        addr      <= '0;
        we        <= 1'b0;
        wd        <= '0;
        exp_valid <= 1'b0;
        exp_data  <= '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        check_read(A_CR, 32'h0);
        bus_write(A_DR, 32'habcd_1234);
        check_read(A_DR, 32'habcd_1234 & ((32'h1 << DIV_W) - 32'h1));
        bus_write(A_CR, 32'hffff_fffc);                         // enables only
        check_read(A_CR, 32'h0000_000c);
        bus_write(A_TX, 32'h1234_56a5);
        check_read(A_TX, 32'h0000_00a5);
        bus_write(A_RX, 32'h0000_005a);                         // read only, ignored
        check_read(A_RX, 32'h0);
        check_read(BASE | 32'h2, 32'h0);                        // unknown offset
        repeat (N_RAND)
        begin
            take_bits(4);
            div = 3 + int'(rnd) % 13;
            take_bits(8);
            loopback_byte(rnd[7 : 0], div, 1'b1);
            bus_write(A_CR, ctrl_word(1'b0, 1'b0, 1'b1, 1'b1)); // ack rx_val
            check_read(A_CR, ctrl_word(1'b0, 1'b0, 1'b1, 1'b1));
        end
        take_bits(4);
        div = 3 + int'(rnd) % 13;
        take_bits(8);
        data = rnd[7 : 0];
        bus_write(A_DR, 32'(div));
        bus_write(A_TX, {24'h0, data});
        bus_write(A_CR, ctrl_word(1'b1, 1'b0, 1'b0, 1'b1));    // request with tx off
        frames_before = frames_done;
        repeat (20 * (div + 1)) @(posedge clk);
        if (frames_done != frames_before)
        begin
            seq_errs++;
            $display("uart_tx sent a frame while tx_en was 0");
        end
        check_read(A_CR, ctrl_word(1'b1, 1'b0, 1'b0, 1'b1));   // still pending
        loopback_byte(data, div, 1'b0);                         // tx_en releases it
        bus_write(A_CR, ctrl_word(1'b0, 1'b0, 1'b0, 1'b1));
        check_read(A_CR, ctrl_word(1'b0, 1'b0, 1'b0, 1'b1));   // enables as written
        bus_write(A_TX, {24'h0, ~data});
        bus_write(A_CR, ctrl_word(1'b1, 1'b0, 1'b1, 1'b0));    // receiver off
        poll_ctrl(5'd0, 1'b0, 12 * (div + 1), "tx_req clear with receiver off");
        repeat (4 * (div + 1)) @(posedge clk);
        check_read(A_CR, ctrl_word(1'b0, 1'b0, 1'b1, 1'b0));   // rx_val stays 0
        if (frames_done != N_FRAMES)
        begin
            seq_errs++;
            $display("%0d frames were checked on uart_tx instead of %0d", frames_done, N_FRAMES);
        end
        $display("errors: checker %0d, sequence %0d", chk_errs, seq_errs);
        if ((chk_errs == 0) && (seq_errs == 0))
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule : tb_uart_top

// File: uart_checker.sv
`timescale 1ns/10ps

module uart_checker
#(
    parameter int DIV_W = uart_pkg::DIV_MAX_W                   // live divider bits
)
(
    input   logic               clk,
    input   logic               rst_n,
    input   logic   [31 : 0]    addr,
    input   logic               we,
    input   logic   [31 : 0]    wd,
    input   logic   [31 : 0]    rd,
    input   logic               uart_tx,
    input   logic               exp_valid,                      // compare rd this cycle
    input   logic   [31 : 0]    exp_data,
    output  int                 err_cnt,
    output  int                 frames_done                     // frames fully sampled
);

    import uart_pkg::*;

    logic   [7 : 0]         tx_byte_q;                          // last byte written to TX
    logic   [DIV_W-1 : 0]   div_q;                              // last divider written
    logic                   tx_prev;
    logic                   in_frame;
    int unsigned            period;                             // cycles per bit
    int unsigned            cnt;                                // cycles since start fall
    int unsigned            bit_idx;
    logic                   exp_bit;

    // line level at bit k of an 8N1 frame, lsb first
    function automatic logic expected_line(input logic [7 : 0] b, input int unsigned k);
        if (k == 0)
            return 1'b0;                                        // start
        else if (k <= 8)
            return b[3'(k - 1)];
        else
            return 1'b1;                                        // stop
    endfunction

    always @(negedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            err_cnt     = 0;
            frames_done = 0;
            tx_byte_q   = '0;
            div_q       = '0;
            tx_prev     = 1'b1;
            in_frame    = 1'b0;
            period      = 1;
            cnt         = 0;
        end
        else
        begin
            if (we && (uart_reg_e'(addr[3 : 0]) == UART_TX))
                tx_byte_q = wd[7 : 0];                          // snoop bus writes
            if (we && (uart_reg_e'(addr[3 : 0]) == UART_DR))
                div_q = wd[DIV_W-1 : 0];
            if (exp_valid && (rd !== exp_data))
            begin
                err_cnt++;
                $display("Fail rd at addr %h got %h exp %h", addr, rd, exp_data);
            end
            if (!in_frame && tx_prev && !uart_tx)
            begin
                in_frame = 1'b1;                                // start bit seen
                period   = 32'(div_q) + 32'd1;
                cnt      = 0;
            end
            if (in_frame)
            begin
                if ((cnt % period) == (period / 2))
                begin
                    bit_idx = cnt / period;                     // mid-bit sample
                    exp_bit = expected_line(tx_byte_q, bit_idx);
                    if (uart_tx !== exp_bit)
                    begin
                        err_cnt++;
                        $display("Fail uart_tx bit %0d got %h exp %h", bit_idx, uart_tx, exp_bit);
                    end
                    if (bit_idx == 9)
                    begin
                        in_frame = 1'b0;
                        frames_done++;
                    end
                end
                cnt++;
            end
            tx_prev = uart_tx;
        end
    end

endmodule : uart_checker

// File: uart_sva.sv
`timescale 1ns/10ps

module uart_sva
(
    input   logic   clk,
    input   logic   rst_n,
    input   logic   uart_tx,
    input   logic   tx_start,
    input   logic   tx_busy,
    input   logic   tx_done,
    input   logic   rx_strobe
);

    // line idles high outside a frame
    idle_high : assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> uart_tx)
        else $error("uart_tx low with no frame active");

    // a start makes the serializer busy and is not repeated
    start_when_idle : assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |=> (tx_busy && !tx_start))
        else $error("serializer not busy after tx_start or tx_start raised again");

    done_pulse : assert property (@(posedge clk) disable iff (!rst_n) tx_done |=> !tx_done)
        else $error("tx_done held longer than one cycle");

    strobe_pulse : assert property (@(posedge clk) disable iff (!rst_n) rx_strobe |=> !rx_strobe)
        else $error("rx_strobe held longer than one cycle");

endmodule : uart_sva

bind uart_top uart_sva u_sva
(
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .uart_tx    ( uart_tx   ),
    .tx_start   ( tx_start  ),
    .tx_busy    ( tx_busy   ),
    .tx_done    ( tx_done   ),
    .rx_strobe  ( rx_strobe )
);

// File: uart_top.sv
`timescale 1ns/10ps

module uart_top
#(
    parameter int DIV_W = 16                                    // divider bits in use
)
(
    input   logic                   clk,                        // system clock
    input   logic                   rst_n,                      // async reset active low
    // processor bus
    input   logic   [31 : 0]        addr,                       // byte address
    input   logic                   we,                         // write strobe
    input   logic   [31 : 0]        wd,                         // write data
    output  logic   [31 : 0]        rd,                         // read data
    // serial pins
    output  logic                   uart_tx,                    // transmit line
    input   logic                   uart_rx                     // receive line
);

    import uart_pkg::*;

    uart_cfg_t              cfg;                                // enables and divider
    logic   [7 : 0]         tx_data;                            // byte to send
    logic                   tx_start;                           // launch strobe
    logic                   tx_busy;                            // frame in flight
    logic                   tx_done;                            // frame end strobe
    logic   [7 : 0]         rx_byte;                            // received byte
    logic                   rx_strobe;                          // byte valid pulse

    // register block
    uart_bus_regs #(.DIV_W(DIV_W)) u_regs
    (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .addr       ( addr          ),
        .we         ( we            ),
        .wd         ( wd            ),
        .rd         ( rd            ),
        .tx_busy    ( tx_busy       ),
        .tx_done    ( tx_done       ),                          // clears tx_req
        .rx_strobe  ( rx_strobe     ),                          // sets rx_val
        .rx_byte    ( rx_byte       ),
        .cfg        ( cfg           ),
        .tx_data    ( tx_data       ),
        .tx_start   ( tx_start      )
    );

    // transmitter
    uart_tx_serializer #(.DIV_W(DIV_W)) u_tx
    (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .cfg        ( cfg           ),
        .tx_data    ( tx_data       ),
        .tx_start   ( tx_start      ),
        .tx_busy    ( tx_busy       ),
        .tx_done    ( tx_done       ),
        .uart_tx    ( uart_tx       )
    );

    // receiver
    uart_rx_sampler #(.DIV_W(DIV_W)) u_rx
    (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .cfg        ( cfg           ),
        .uart_rx    ( uart_rx       ),                          // async pin
        .rx_byte    ( rx_byte       ),
        .rx_strobe  ( rx_strobe     )
    );

endmodule : uart_top

// File: uart_rx_sampler.sv
`timescale 1ns/10ps

module uart_rx_sampler
#(
    parameter int DIV_W = uart_pkg::DIV_MAX_W                   // live divider bits
)
(
    input   logic                   clk,                        // system clock
    input   logic                   rst_n,                      // async reset active low
    input   uart_pkg::uart_cfg_t    cfg,                        // rx_en and divider
    input   logic                   uart_rx,                    // serial line in
    output  logic   [7 : 0]         rx_byte,                    // assembled byte
    output  logic                   rx_strobe                   // byte valid pulse
);

    import uart_pkg::*;

    localparam int BIT_CNT_W = $clog2(UART_DATA_BITS);          // data bit index width

    logic                               rx_meta;                // first sync flop
    logic                               rx_sync;                // second sync flop
    rx_state_e                          state;                  // frame phase
    logic   [DIV_W-1 : 0]               div;                    // bit period minus one
    logic   [DIV_W-1 : 0]               baud_cnt;               // cycles to next sample
    logic                               tick;                   // sample point
    logic   [BIT_CNT_W-1 : 0]           bit_cnt;                // data bit being sampled
    logic                               last_bit;               // sampling bit 7
    logic   [UART_DATA_BITS-1 : 0]      shift_q;                // payload lsb first

    assign div      = cfg.divider[DIV_W-1 : 0];
    assign tick     = (baud_cnt == '0);
    assign last_bit = (bit_cnt == BIT_CNT_W'(UART_DATA_BITS - 1));

    // two-flop synchronizer
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rx_meta <= UART_STOP_BIT;                           // assume idle line
            rx_sync <= UART_STOP_BIT;
        end
        else
        begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
        end
    end

    // FSM and counters held in idle while receiver is off
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end
        else if (!cfg.rx_en)
            state <= RX_IDLE;
        else
        begin
            case (state)
                RX_IDLE :
                    if (rx_sync == UART_START_BIT)
                    begin
                        state    <= RX_START;
                        baud_cnt <= div >> 1;                   // half period to mid start
                    end
                RX_START :
                    if (!tick)
                        baud_cnt <= baud_cnt - 1'b1;
                    else if (rx_sync == UART_START_BIT)
                    begin
                        state    <= RX_DATA;
                        baud_cnt <= div;
                        bit_cnt  <= '0;
                    end
                    else
                        state <= RX_IDLE;                       // glitch not a start bit
                RX_DATA :
                    if (!tick)
                        baud_cnt <= baud_cnt - 1'b1;
                    else
                    begin
                        baud_cnt <= div;                        // one full period to next bit
                        if (last_bit)
                            state <= RX_STOP;
                        else
                            bit_cnt <= bit_cnt + 1'b1;
                    end
                RX_STOP :
                    if (!tick)
                        baud_cnt <= baud_cnt - 1'b1;
                    else
                        state <= RX_IDLE;                       // rearm mid stop bit
                default :
                    state <= RX_IDLE;
            endcase
        end
    end

    // shift in at each data sample point
    always_ff @(posedge clk)
    begin
        if (cfg.rx_en && (state == RX_DATA) && tick)
            shift_q <= {rx_sync, shift_q[UART_DATA_BITS-1 : 1]};
    end

    assign rx_byte   = shift_q;
    // bad stop bit drops the frame
    assign rx_strobe = cfg.rx_en && (state == RX_STOP) && tick && (rx_sync == UART_STOP_BIT);

endmodule : uart_rx_sampler

// File: uart_tx_serializer.sv
`timescale 1ns/10ps

module uart_tx_serializer
#(
    parameter int DIV_W = uart_pkg::DIV_MAX_W                   // live divider bits
)
(
    input   logic                   clk,                        // system clock
    input   logic                   rst_n,                      // async reset active low
    input   uart_pkg::uart_cfg_t    cfg,                        // divider source
    input   logic   [7 : 0]         tx_data,                    // byte to send
    input   logic                   tx_start,                   // launch strobe
    output  logic                   tx_busy,                    // frame in flight
    output  logic                   tx_done,                    // last cycle of frame
    output  logic                   uart_tx                     // serial line
);

    import uart_pkg::*;

    localparam int BIT_CNT_W = $clog2(UART_DATA_BITS);          // data bit index width

    tx_state_e                          state;                  // frame phase
    logic   [DIV_W-1 : 0]               div;                    // bit period minus one
    logic   [DIV_W-1 : 0]               baud_cnt;               // cycles left in bit
    logic                               tick;                   // last cycle of a bit
    logic   [BIT_CNT_W-1 : 0]           bit_cnt;                // data bit being sent
    logic                               last_bit;               // bit 7 on the line
    logic   [UART_DATA_BITS-1 : 0]      shift_q;                // remaining payload

    assign div      = cfg.divider[DIV_W-1 : 0];
    assign tick     = (baud_cnt == '0);
    assign last_bit = (bit_cnt == BIT_CNT_W'(UART_DATA_BITS - 1));
    assign tx_busy  = (state != TX_IDLE);
    assign tx_done  = (state == TX_STOP) && tick;               // one cycle by construction

    // down counter gives divider+1 cycles per bit
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            baud_cnt <= '0;
        else if ((state == TX_IDLE) || tick)
            baud_cnt <= div;                                    // preload keeps start bit full
        else
            baud_cnt <= baud_cnt - 1'b1;
    end

    // byte latched on start then shifted lsb first
    always_ff @(posedge clk)
    begin
        if ((state == TX_IDLE) && tx_start)
            shift_q <= tx_data;
        else if (tick && ((state == TX_START) || (state == TX_DATA)))
            shift_q <= {1'b0, shift_q[UART_DATA_BITS-1 : 1]};
    end

    // frame FSM with a registered line output
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            uart_tx <= UART_STOP_BIT;                           // idle high
        end
        else
        begin
            case (state)
                TX_IDLE :
                    if (tx_start)
                    begin
                        state   <= TX_START;
                        uart_tx <= UART_START_BIT;              // falls the cycle after start
                    end
                TX_START :
                    if (tick)
                    begin
                        state   <= TX_DATA;
                        bit_cnt <= '0;
                        uart_tx <= shift_q[0];                  // data bit 0
                    end
                TX_DATA :
                    if (tick)
                    begin
                        if (last_bit)
                        begin
                            state   <= TX_STOP;
                            uart_tx <= UART_STOP_BIT;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            uart_tx <= shift_q[0];              // already shifted down
                        end
                    end
                TX_STOP :
                    if (tick)
                        state <= TX_IDLE;                       // line stays high
                default :
                    state <= TX_IDLE;
            endcase
        end
    end

endmodule : uart_tx_serializer

// File: uart_bus_regs.sv
`timescale 1ns/10ps

module uart_bus_regs
#(
    parameter int DIV_W = uart_pkg::DIV_MAX_W                   // live divider bits
)
(
    input   logic                   clk,                        // system clock
    input   logic                   rst_n,                      // async reset active low
    // processor bus
    input   logic   [31 : 0]        addr,                       // byte address
    input   logic                   we,                         // one-cycle write strobe
    input   logic   [31 : 0]        wd,                         // write data
    output  logic   [31 : 0]        rd,                         // read data
    // engine side
    input   logic                   tx_busy,                    // frame in flight
    input   logic                   tx_done,                    // last cycle of stop bit
    input   logic                   rx_strobe,                  // good byte received
    input   logic   [7 : 0]         rx_byte,                    // byte from sampler
    output  uart_pkg::uart_cfg_t    cfg,                        // enables and divider
    output  logic   [7 : 0]         tx_data,                    // byte to send
    output  logic                   tx_start                    // launch one frame
);

    import uart_pkg::*;

    uart_reg_e              reg_sel;                            // decoded offset
    uart_ctrl_t             ctrl_q;                             // control register
    uart_ctrl_t             ctrl_wd;                            // control view of wd
    logic   [7 : 0]         rx_data_q;                          // receive register
    logic   [DIV_W-1 : 0]   div_q;                              // divider register
    logic                   cr_we;                              // control write
    logic                   tx_we;                              // transmit data write
    logic                   dr_we;                              // divider write

    assign reg_sel = uart_reg_e'(addr[3 : 0]);                  // low nibble picks register
    assign ctrl_wd = uart_ctrl_t'(wd[UART_CTRL_W-1 : 0]);

    assign cr_we = we && (reg_sel == UART_CR);
    assign tx_we = we && (reg_sel == UART_TX);
    assign dr_we = we && (reg_sel == UART_DR);                 // UART_RX is read only

    // enables follow the written word
    // tx_req and rx_val are set/clear bits where engine events win
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ctrl_q <= '0;
        else
        begin
            if (cr_we)
            begin
                ctrl_q.tx_en <= ctrl_wd.tx_en;
                ctrl_q.rx_en <= ctrl_wd.rx_en;
            end
            if (tx_done)
                ctrl_q.tx_req <= 1'b0;                          // frame finished
            else if (cr_we && ctrl_wd.tx_req)
                ctrl_q.tx_req <= 1'b1;                          // writing 0 leaves it alone
            if (rx_strobe)
                ctrl_q.rx_val <= 1'b1;                          // new byte landed
            else if (cr_we)
                ctrl_q.rx_val <= ctrl_wd.rx_val;                // software ack by writing 0
        end
    end

    // data and divider registers
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            tx_data   <= '0;
            rx_data_q <= '0;
            div_q     <= '0;
        end
        else
        begin
            if (tx_we)
                tx_data <= wd[7 : 0];
            if (rx_strobe)
                rx_data_q <= rx_byte;                           // newest byte overwrites
            if (dr_we)
                div_q <= wd[DIV_W-1 : 0];
        end
    end

    // pending request fires once tx is enabled and idle
    // tx_busy rises next cycle so this is a single pulse
    assign tx_start = ctrl_q.tx_req && ctrl_q.tx_en && !tx_busy;

    always_comb
    begin
        cfg                      = '0;
        cfg.tx_en                = ctrl_q.tx_en;
        cfg.rx_en                = ctrl_q.rx_en;
        cfg.divider[DIV_W-1 : 0] = div_q;                       // upper bits stay zero
    end

    // read mux straight from addr
    always_comb
    begin
        rd = '0;                                                // unknown offset reads zero
        case (reg_sel)
            UART_CR : rd[UART_CTRL_W-1 : 0] = ctrl_q;
            UART_TX : rd[7 : 0]             = tx_data;
            UART_RX : rd[7 : 0]             = rx_data_q;
            UART_DR : rd[DIV_W-1 : 0]       = div_q;
            default : ;
        endcase
    end

endmodule : uart_bus_regs

// File: uart_pkg.sv
package uart_pkg;

    localparam int DIV_MAX_W        = 16;       // widest divider the register map holds
    localparam int UART_DATA_BITS   = 8;        // payload bits per 8N1 frame
    localparam int UART_CTRL_W      = 4;        // live bits of the control register

    localparam logic UART_START_BIT = 1'b0;     // line level during start bit
    localparam logic UART_STOP_BIT  = 1'b1;     // line level during stop bit and idle

    // register offsets seen on addr[3:0]
    typedef enum logic [3 : 0]
    {
        UART_CR = 4'h0,                         // control
        UART_TX = 4'h4,                         // transmit data
        UART_RX = 4'h8,                         // receive data
        UART_DR = 4'hc                          // baud divider
    } uart_reg_e;

    // control word in the order of wd[3:0]
    typedef struct packed
    {
        logic   rx_en;                          // bit 3 receiver enable
        logic   tx_en;                          // bit 2 transmitter enable
        logic   rx_val;                         // bit 1 byte waiting in UART_RX
        logic   tx_req;                         // bit 0 frame requested or in flight
    } uart_ctrl_t;

    // static setup handed to both engines
    typedef struct packed
    {
        logic                       tx_en;      // transmit side enabled
        logic                       rx_en;      // receive side enabled
        logic   [DIV_MAX_W-1 : 0]   divider;    // bit period minus one
    } uart_cfg_t;

    // transmit serializer states
    typedef enum logic [1 : 0]
    {
        TX_IDLE,                                // line high, waiting for start
        TX_START,                               // driving start bit
        TX_DATA,                                // shifting payload lsb first
        TX_STOP                                 // driving stop bit
    } tx_state_e;

    // receive sampler states
    typedef enum logic [1 : 0]
    {
        RX_IDLE,                                // hunting for a falling edge
        RX_START,                               // waiting half a period to confirm
        RX_DATA,                                // sampling payload mid-bit
        RX_STOP                                 // checking stop bit
    } rx_state_e;

endpackage : uart_pkg
